/* fifo_to_host.f */
+incdir+src
src/fifo_to_host_pkg.sv
src/line_fifo.sv
src/ring_writer.sv
src/ring_status.sv
src/write_channel.sv
src/fifo_to_host.sv
testbench/tb_clock_gen.sv
testbench/tb_fifo_to_host.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f fifo_to_host.f --top-module tb_fifo_to_host -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_fifo_to_host" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -q "^Done: no errors$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

/* src/fifo_to_host.sv */
// Top level of the host-bound message channel
// Input FIFO, ring writer, ring status and memory write channel

`timescale 1ns/1ps

module fifo_to_host
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hc_en,
    input  fifo_to_host_pkg::t_line_addr buffer_base,
    input  fifo_to_host_pkg::t_line_data tx_data,
    input  logic                         tx_enable,
    output logic                         tx_rdy,
    input  fifo_to_host_pkg::t_ring_idx  host_oldest_idx,
    input  logic                         host_oldest_valid,
    output fifo_to_host_pkg::t_ring_idx  next_write_idx,
    output logic                         host_notify,
    output logic                         mem_req,
    input  logic                         mem_ack,
    output fifo_to_host_pkg::t_line_addr mem_addr,
    output fifo_to_host_pkg::t_line_data mem_data,
    output logic                         mem_fence
);

    // FIFO to writer
    fifo_to_host_pkg::t_line_data line_data;
    logic line_valid;
    logic line_deq;

    // Writer to channel
    logic wr_request;
    fifo_to_host_pkg::t_line_addr wr_addr;
    fifo_to_host_pkg::t_line_data wr_data;
    logic wr_fence;
    logic wr_grant;
    logic chan_idle;

    // Ring bookkeeping
    logic ring_full;
    fifo_to_host_pkg::t_ring_idx cur_idx;
    fifo_to_host_pkg::t_ring_idx written_idx;

    // Producer lines are buffered before the ring writer
    line_fifo u_line_fifo
    (
        .clk       (clk),
        .reset     (reset),
        .enq_data  (tx_data),
        .enq_en    (tx_enable),
        .not_full  (tx_rdy),
        .first     (line_data),
        .deq_en    (line_deq),
        .not_empty (line_valid)
    );

    ring_writer u_ring_writer
    (
        .clk         (clk),
        .reset       (reset),
        .hc_en       (hc_en),
        .buffer_base (buffer_base),
        .line_data   (line_data),
        .line_valid  (line_valid),
        .line_deq    (line_deq),
        .ring_full   (ring_full),
        .wr_request  (wr_request),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_fence    (wr_fence),
        .wr_grant    (wr_grant),
        .chan_idle   (chan_idle),
        .cur_idx     (cur_idx),
        .written_idx (written_idx)
    );

    ring_status u_ring_status
    (
        .clk               (clk),
        .reset             (reset),
        .host_oldest_idx   (host_oldest_idx),
        .host_oldest_valid (host_oldest_valid),
        .cur_idx           (cur_idx),
        .written_idx       (written_idx),
        .ring_full         (ring_full),
        .next_write_idx    (next_write_idx),
        .host_notify       (host_notify)
    );

    write_channel u_write_channel
    (
        .clk        (clk),
        .reset      (reset),
        .wr_request (wr_request),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_fence   (wr_fence),
        .wr_grant   (wr_grant),
        .chan_idle  (chan_idle),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_fence  (mem_fence)
    );

endmodule

/* src/fifo_to_host_consts.svh */
// Shared constants for the host-bound message channel
// Line, address, ring index and idle counter widths
// Depth of the input line FIFO

`ifndef FIFO_TO_HOST_CONSTS_SVH
`define FIFO_TO_HOST_CONSTS_SVH

// ==================================================
// Datapath widths
// ==================================================

// Width of one message line
`define FTH_DATA_W 64

// Width of a memory line address
`define FTH_ADDR_W 32

// ==================================================
// Ring and flush control
// ==================================================

// Ring index width for a 64-entry ring in host memory
`define FTH_IDX_W 6

// Idle counter width
// Its top bit requests a flush after 16 counted idle cycles
`define FTH_IDLE_W 5

// Number of lines buffered between the producer and the ring writer
`define FTH_FIFO_DEPTH 2

`endif

/* src/fifo_to_host_pkg.sv */
// Type package for the host-bound message channel
// Vector typedefs for lines, addresses and ring indices
// State encoding of the ring writer FSM

`include "fifo_to_host_consts.svh"

package fifo_to_host_pkg;

    // ==================================================
    // Datapath types
    // ==================================================

    // One message line as it is written to host memory
    typedef logic [`FTH_DATA_W-1:0] t_line_data;

    // Line address in host memory
    typedef logic [`FTH_ADDR_W-1:0] t_line_addr;

    // Entry index within the ring buffer
    // Arithmetic on it wraps naturally around the ring
    typedef logic [`FTH_IDX_W-1:0] t_ring_idx;

    // ==================================================
    // Ring writer FSM
    // ==================================================

    // In wait_empty no lines are unpublished since the last fence
    // In wait_data lines are written and wait for a reason to fence
    // In emit_fence a fence request is pending on the write channel
    typedef enum logic [1:0]
    {
        wait_empty,
        wait_data,
        emit_fence
    } t_writer_state;

endpackage

/* src/line_fifo.sv */
// Input line FIFO
// Small register FIFO between the producer and the ring writer
// Supports enqueue and dequeue in the same cycle

`timescale 1ns/1ps

`include "fifo_to_host_consts.svh"

module line_fifo
(
    input  logic                        clk,
    input  logic                        reset,
    input  fifo_to_host_pkg::t_line_data enq_data,
    input  logic                        enq_en,
    output logic                        not_full,
    output fifo_to_host_pkg::t_line_data first,
    input  logic                        deq_en,
    output logic                        not_empty
);

    localparam int DEPTH = `FTH_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, read and write pointers and occupancy
    fifo_to_host_pkg::t_line_data storage [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic do_enq;
    logic do_deq;

    // Advance a pointer and wrap it after the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // Ready toward the producer whenever an entry is free
    assign not_full = (count != CNT_W'(DEPTH));
    assign not_empty = (count != '0);

    // A producer strobe while full is ignored, as is a dequeue while empty
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // The oldest line is always presented at the read pointer
    assign first = storage[rd_ptr];

    // Each accepted line is stored at the write pointer
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            storage[wr_ptr] <= enq_data;
        end
    end

    // Pointer and occupancy tracking
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end

            if (do_deq)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end

            // Simultaneous enqueue and dequeue leave the occupancy unchanged
            case ({do_enq, do_deq})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/ring_status.sv */
// Ring status
// Holds the oldest index still owned by the host and derives ring full
// Publishes the committed write index with a notify pulse

`timescale 1ns/1ps

module ring_status
(
    input  logic                        clk,
    input  logic                        reset,
    input  fifo_to_host_pkg::t_ring_idx host_oldest_idx,
    input  logic                        host_oldest_valid,
    input  fifo_to_host_pkg::t_ring_idx cur_idx,
    input  fifo_to_host_pkg::t_ring_idx written_idx,
    output logic                        ring_full,
    output fifo_to_host_pkg::t_ring_idx next_write_idx,
    output logic                        host_notify
);

    // Oldest entry the host has not yet consumed
    fifo_to_host_pkg::t_ring_idx oldest_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            oldest_idx <= '0;
        end
        else if (host_oldest_valid)
        begin
            oldest_idx <= host_oldest_idx;
        end
    end

    // One slot stays empty so that a full ring differs from an empty one
    assign ring_full = ((cur_idx + fifo_to_host_pkg::t_ring_idx'(1)) == oldest_idx);

    // ==================================================
    // Index publication
    // ==================================================

    // The notify pulse lines up with the cycle the new index appears
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_write_idx <= '0;
            host_notify <= 1'b0;
        end
        else
        begin
            next_write_idx <= written_idx;
            host_notify <= (written_idx != next_write_idx);
        end
    end

endmodule

/* src/ring_writer.sv */
// Ring writer
// Turns buffered lines into ring buffer writes in host memory
// Emits a fence after an idle run or a quarter of the ring
// Tracks the current and the fenced (written) ring index

`timescale 1ns/1ps

`include "fifo_to_host_consts.svh"

module ring_writer
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hc_en,
    input  fifo_to_host_pkg::t_line_addr buffer_base,
    input  fifo_to_host_pkg::t_line_data line_data,
    input  logic                         line_valid,
    output logic                         line_deq,
    input  logic                         ring_full,
    output logic                         wr_request,
    output fifo_to_host_pkg::t_line_addr wr_addr,
    output fifo_to_host_pkg::t_line_data wr_data,
    output logic                         wr_fence,
    input  logic                         wr_grant,
    input  logic                         chan_idle,
    output fifo_to_host_pkg::t_ring_idx  cur_idx,
    output fifo_to_host_pkg::t_ring_idx  written_idx
);

    fifo_to_host_pkg::t_writer_state state;

    // Consecutive idle cycles while lines are waiting for a fence
    logic [`FTH_IDLE_W-1:0] idle_cycles;

    logic flush_for_idle;
    logic flush_for_idle_hold;
    logic flush_for_writes;
    logic fence_granted;

    // ==================================================
    // Flush triggers
    // ==================================================

    // A change in the second-highest index bit means another quarter
    // of the ring has been written since the last fence
    assign flush_for_writes = (cur_idx[`FTH_IDX_W-2] != written_idx[`FTH_IDX_W-2]);

    // The idle flush stays requested until the fence goes out
    assign flush_for_idle = idle_cycles[`FTH_IDLE_W-1] || flush_for_idle_hold;

    assign fence_granted = wr_grant && (state == fifo_to_host_pkg::emit_fence);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            flush_for_idle_hold <= 1'b0;
        end
        else if (fence_granted)
        begin
            flush_for_idle_hold <= 1'b0;
        end
        else if (idle_cycles[`FTH_IDLE_W-1])
        begin
            flush_for_idle_hold <= 1'b1;
        end
    end

    // Count only while the channel has nothing in flight, so a saturated
    // memory port does not cause extra fences
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idle_cycles <= '0;
        end
        else if ((state != fifo_to_host_pkg::wait_data) || line_deq)
        begin
            idle_cycles <= '0;
        end
        else if (chan_idle)
        begin
            idle_cycles <= idle_cycles + `FTH_IDLE_W'(1);
        end
    end

    // ==================================================
    // Ring index FSM
    // ==================================================

    // A grant outside emit_fence always belongs to a line write
    assign line_deq = wr_grant && (state != fifo_to_host_pkg::emit_fence);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= fifo_to_host_pkg::wait_empty;
            cur_idx <= '0;
            written_idx <= '0;
        end
        else
        begin
            case (state)
                fifo_to_host_pkg::wait_empty:
                begin
                    // First line after a fence opens a new batch
                    if (wr_grant)
                    begin
                        cur_idx <= cur_idx + `FTH_IDX_W'(1);
                        state <= fifo_to_host_pkg::wait_data;
                    end
                end

                fifo_to_host_pkg::wait_data:
                begin
                    if (wr_grant)
                    begin
                        cur_idx <= cur_idx + `FTH_IDX_W'(1);
                    end

                    // Time to make the batch visible to the host
                    if (flush_for_idle || flush_for_writes)
                    begin
                        state <= fifo_to_host_pkg::emit_fence;
                    end
                end

                fifo_to_host_pkg::emit_fence:
                begin
                    // Everything before the fence is now committed
                    if (wr_grant)
                    begin
                        written_idx <= cur_idx;
                        state <= fifo_to_host_pkg::wait_empty;
                    end
                end

                default:
                begin
                    state <= fifo_to_host_pkg::wait_empty;
                end
            endcase
        end
    end

    // ==================================================
    // Write request
    // ==================================================

    // Nothing is issued while disabled or while the host has not freed space
    assign wr_request = hc_en && !ring_full &&
                        (line_valid || (state == fifo_to_host_pkg::emit_fence));

    assign wr_fence = (state == fifo_to_host_pkg::emit_fence);

    // Fences carry address 0; lines go to their ring slot
    assign wr_addr = wr_fence ? '0 :
                     buffer_base + fifo_to_host_pkg::t_line_addr'(cur_idx);

    assign wr_data = line_data;

endmodule

/* src/write_channel.sv */
// Write channel
// Grants one writer request at a time and carries it to memory
// Runs a four-phase req/ack handshake on the memory port

`timescale 1ns/1ps

module write_channel
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_request,
    input  fifo_to_host_pkg::t_line_addr wr_addr,
    input  fifo_to_host_pkg::t_line_data wr_data,
    input  logic                         wr_fence,
    output logic                         wr_grant,
    output logic                         chan_idle,
    output logic                         mem_req,
    input  logic                         mem_ack,
    output fifo_to_host_pkg::t_line_addr mem_addr,
    output fifo_to_host_pkg::t_line_data mem_data,
    output logic                         mem_fence
);

    // Handshake phases on the memory port
    typedef enum logic [1:0]
    {
        ph_idle,
        ph_wait_ack_high,
        ph_wait_ack_low
    } t_phase;

    t_phase phase;

    // A transaction is in progress from grant until ack has fallen
    assign chan_idle = (phase == ph_idle);

    // Grant is only possible while idle, so it lasts a single cycle
    assign wr_grant = chan_idle && wr_request;

    // ==================================================
    // Handshake sequencing
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= ph_idle;
            mem_req <= 1'b0;
        end
        else
        begin
            case (phase)
                ph_idle:
                begin
                    // Raise req on the edge after the grant
                    if (wr_grant)
                    begin
                        mem_req <= 1'b1;
                        phase <= ph_wait_ack_high;
                    end
                end

                ph_wait_ack_high:
                begin
                    if (mem_ack)
                    begin
                        mem_req <= 1'b0;
                        phase <= ph_wait_ack_low;
                    end
                end

                ph_wait_ack_low:
                begin
                    // Memory has closed the handshake
                    if (!mem_ack)
                    begin
                        phase <= ph_idle;
                    end
                end

                default:
                begin
                    mem_req <= 1'b0;
                    phase <= ph_idle;
                end
            endcase
        end
    end

    // Request fields are captured at grant and held for the whole handshake
    always_ff @(posedge clk)
    begin
        if (wr_grant)
        begin
            mem_addr <= wr_addr;
            mem_data <= wr_data;
            mem_fence <= wr_fence;
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
// Clock and reset source for the testbench
// 8 ns clock, reset held high for the first 10 cycles

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released on a rising edge like any other synchronous input
    initial
    begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* testbench/tb_fifo_to_host.sv */
// Testbench for the host-bound message channel
// Stimulus table applied row by row, memory responder model,
// host notify monitor, scoreboard checks and closing summary

`timescale 1ns/1ps

`include "fifo_to_host_consts.svh"

module tb_fifo_to_host;

    localparam int NUM_ROWS = 5;
    localparam int WAIT_LIMIT = 4000;
    localparam int RING_SLOTS = 63;
    localparam logic [`FTH_ADDR_W-1:0] BASE = 32'h0004_0000;

    logic clk;
    logic reset;
    logic hc_en;
    logic [`FTH_ADDR_W-1:0] buffer_base;
    logic [`FTH_DATA_W-1:0] tx_data;
    logic tx_enable;
    logic tx_rdy;
    logic [`FTH_IDX_W-1:0] host_oldest_idx;
    logic host_oldest_valid;
    logic [`FTH_IDX_W-1:0] next_write_idx;
    logic host_notify;
    logic mem_req;
    logic mem_ack;
    logic [`FTH_ADDR_W-1:0] mem_addr;
    logic [`FTH_DATA_W-1:0] mem_data;
    logic mem_fence;

    // Stimulus table columns
    string row_name [NUM_ROWS];
    int row_lines [NUM_ROWS];
    int row_delay [NUM_ROWS];
    int row_en_low [NUM_ROWS];
    int row_consume [NUM_ROWS];

    string cur_test;
    int ack_delay;
    int sent_count;
    int value_errors;
    int other_errors;
    int checks;

    // Expected ring index that advances once per accepted line
    logic [`FTH_IDX_W-1:0] exp_idx;

    // Scoreboard entries hold address and data together
    logic [`FTH_ADDR_W+`FTH_DATA_W-1:0] exp_q [$];
    logic [`FTH_ADDR_W+`FTH_DATA_W-1:0] got_q [$];

    // Owned by the memory responder
    int lines_rcv;
    int fence_count;
    int trans_count;
    int fence_marks [$];
    logic [`FTH_ADDR_W-1:0] fence_addrs [$];
    logic pending_fence;

    // Owned by the notify monitor
    logic [`FTH_IDX_W-1:0] pub_values [$];

    // Snapshots taken at the start of each row
    logic [`FTH_IDX_W-1:0] row_first_idx;
    int row_first_lines;
    int row_first_trans;
    int row_first_fences;
    int row_first_pubs;
    int row_first_exp;

    tb_clock_gen u_clock_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    fifo_to_host u_fifo_to_host
    (
        .clk               (clk),
        .reset             (reset),
        .hc_en             (hc_en),
        .buffer_base       (buffer_base),
        .tx_data           (tx_data),
        .tx_enable         (tx_enable),
        .tx_rdy            (tx_rdy),
        .host_oldest_idx   (host_oldest_idx),
        .host_oldest_valid (host_oldest_valid),
        .next_write_idx    (next_write_idx),
        .host_notify       (host_notify),
        .mem_req           (mem_req),
        .mem_ack           (mem_ack),
        .mem_addr          (mem_addr),
        .mem_data          (mem_data),
        .mem_fence         (mem_fence)
    );

    // ==================================================
    // Reporting helpers
    // ==================================================

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %s %s: expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
    endtask

    task automatic stop_on_timeout(input string what);
        other_errors++;
        $display("ERROR %s: gave up waiting for %s", cur_test, what);
        print_summary();
        $display("Done: errors found");
        $finish;
    endtask

    // One sampling step of a bounded wait on the falling edge
    task automatic tick_or_timeout(inout int waited, input string what);
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT)
        begin
            stop_on_timeout(what);
        end
    endtask

    // ==================================================
    // Memory responder and notify monitor
    // ==================================================

    // Sees req on the falling edge and answers on the next rising edge
    initial
    begin
        logic next_ack;
        logic taken;
        int held;
        mem_ack <= 1'b0;
        next_ack = 1'b0;
        taken = 1'b0;
        held = 0;
        lines_rcv = 0;
        fence_count = 0;
        trans_count = 0;
        pending_fence = 1'b0;
        forever
        begin
            @(negedge clk);
            if (reset)
            begin
                next_ack = 1'b0;
                taken = 1'b0;
            end
            else if (mem_req && !mem_ack)
            begin
                // First cycle of a new transaction
                if (!taken)
                begin
                    taken = 1'b1;
                    held = 0;
                    trans_count++;
                    if (mem_fence)
                    begin
                        fence_count++;
                        fence_marks.push_back(lines_rcv);
                        fence_addrs.push_back(mem_addr);
                        pending_fence = 1'b0;
                    end
                    else
                    begin
                        got_q.push_back({mem_addr, mem_data});
                        lines_rcv++;
                        pending_fence = 1'b1;
                    end
                end
                if (held >= ack_delay)
                begin
                    next_ack = 1'b1;
                end
                else
                begin
                    held++;
                end
            end
            else if (!mem_req && mem_ack)
            begin
                next_ack = 1'b0;
                taken = 1'b0;
            end
            @(posedge clk);
            mem_ack <= next_ack;
        end
    end

    // Every notify pulse records the index the host would read
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && host_notify)
            begin
                pub_values.push_back(next_write_idx);
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic load_table();
        row_name[0] = "basic_burst";
        row_lines[0] = 5;
        row_delay[0] = 1;
        row_en_low[0] = 0;
        row_consume[0] = 0;
        row_name[1] = "quarter_fence";
        row_lines[1] = 20;
        row_delay[1] = 0;
        row_en_low[1] = 0;
        row_consume[1] = 0;
        row_name[2] = "enable_gate";
        row_lines[2] = 6;
        row_delay[2] = 2;
        row_en_low[2] = 1;
        row_consume[2] = 0;
        row_name[3] = "slow_memory";
        row_lines[3] = 8;
        row_delay[3] = 12;
        row_en_low[3] = 0;
        row_consume[3] = 0;
        row_name[4] = "ring_full";
        row_lines[4] = 70;
        row_delay[4] = 0;
        row_en_low[4] = 0;
        row_consume[4] = 16;
    endtask

    // Host reports the oldest entry it still holds
    task automatic update_oldest(input logic [`FTH_IDX_W-1:0] idx);
        @(posedge clk);
        host_oldest_idx <= idx;
        host_oldest_valid <= 1'b1;
        @(posedge clk);
        host_oldest_valid <= 1'b0;
    endtask

    task automatic start_row(input int r);
        cur_test = row_name[r];
        ack_delay = row_delay[r];
        sent_count = 0;
        row_first_idx = exp_idx;
        row_first_lines = lines_rcv;
        row_first_trans = trans_count;
        row_first_fences = fence_count;
        row_first_pubs = pub_values.size();
        row_first_exp = exp_q.size();
        // The host has consumed everything written so far
        update_oldest(exp_idx);
        if (row_en_low[r] != 0)
        begin
            @(posedge clk);
            hc_en <= 1'b0;
        end
    endtask

    // A line counts as sent when tx_rdy is high ahead of the rising edge
    task automatic send_lines(input int n);
        int stall;
        logic taken;
        stall = 0;
        @(posedge clk);
        tx_enable <= 1'b1;
        tx_data <= {$urandom(), $urandom()};
        while (sent_count < n)
        begin
            @(negedge clk);
            taken = tx_rdy;
            if (taken)
            begin
                exp_q.push_back({BASE + 32'(exp_idx), tx_data});
                exp_idx = exp_idx + 6'd1;
                sent_count++;
                stall = 0;
            end
            else
            begin
                stall++;
                if (stall > WAIT_LIMIT)
                begin
                    stop_on_timeout("tx_rdy");
                end
            end
            @(posedge clk);
            if (taken && (sent_count < n))
            begin
                tx_data <= {$urandom(), $urandom()};
            end
            else if (taken)
            begin
                tx_enable <= 1'b0;
            end
        end
    endtask

    // Runs beside the producer for rows that gate or stall the writer
    task automatic supervise_row(input int r);
        int waited;
        int held_trans;
        if (row_en_low[r] != 0)
        begin
            waited = 0;
            tick_or_timeout(waited, "tx_rdy to fall");
            while (tx_rdy)
            begin
                tick_or_timeout(waited, "tx_rdy to fall");
            end
            check_value("lines accepted while disabled", 64'd2, 64'(sent_count));
            repeat (8) @(negedge clk);
            check_value("memory requests while disabled", 64'(row_first_trans),
                        64'(trans_count));
            @(posedge clk);
            hc_en <= 1'b1;
        end
        if (row_lines[r] > RING_SLOTS)
        begin
            waited = 0;
            while (lines_rcv - row_first_lines < RING_SLOTS)
            begin
                tick_or_timeout(waited, "the ring to fill");
            end
            held_trans = trans_count;
            repeat (40) @(negedge clk);
            check_value("lines written into a full ring", 64'(RING_SLOTS),
                        64'(lines_rcv - row_first_lines));
            check_value("memory requests while full", 64'(held_trans), 64'(trans_count));
            update_oldest(row_first_idx + 6'(row_consume[r]));
        end
    endtask

    // ==================================================
    // End-of-row checks
    // ==================================================

    task automatic finish_row(input int r);
        int waited;
        int i;
        int mark;
        int pubs;
        logic mid;
        logic [`FTH_IDX_W-1:0] span;
        waited = 0;
        while (lines_rcv - row_first_lines < row_lines[r])
        begin
            tick_or_timeout(waited, "all line writes");
        end
        // A fence must follow the last line, then its notify pulse
        waited = 0;
        while (pending_fence || mem_req || mem_ack)
        begin
            tick_or_timeout(waited, "the closing fence");
        end
        waited = 0;
        while (pub_values.size() - row_first_pubs != fence_count - row_first_fences)
        begin
            tick_or_timeout(waited, "host_notify");
        end
        repeat (3) @(negedge clk);
        pubs = pub_values.size() - row_first_pubs;
        check_value("notify pulses per fence", 64'(fence_count - row_first_fences), 64'(pubs));
        check_value("next_write_idx", 64'(exp_idx), 64'(next_write_idx));
        check_value("lines received", 64'(exp_q.size()), 64'(got_q.size()));
        for (i = row_first_exp; (i < exp_q.size()) && (i < got_q.size()); i++)
        begin
            check_value("line address", 64'(exp_q[i][95:64]), 64'(got_q[i][95:64]));
            check_value("line data", exp_q[i][63:0], got_q[i][63:0]);
        end
        for (i = row_first_fences; i < fence_count; i++)
        begin
            check_value("fence address", 64'd0, 64'(fence_addrs[i]));
        end
        // Rows that cross a quarter boundary well before their end
        if (int'(row_first_idx[3:0]) + row_lines[r] >= 18)
        begin
            mid = 1'b0;
            for (i = row_first_fences; i < fence_count; i++)
            begin
                mark = fence_marks[i];
                if ((mark > row_first_lines) && (mark < row_first_lines + row_lines[r]))
                begin
                    mid = 1'b1;
                end
            end
            check_value("fence among line writes", 64'd1, 64'(mid));
            if (pubs > 0)
            begin
                span = pub_values[row_first_pubs] - row_first_idx;
                check_value("first publish reaches the boundary", 64'd1,
                            64'(int'(span) >= 16 - int'(row_first_idx[3:0])));
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        int r;
        int waited;
        void'($urandom(32'h2429));
        hc_en <= 1'b1;
        buffer_base <= BASE;
        tx_data <= '0;
        tx_enable <= 1'b0;
        host_oldest_idx <= '0;
        host_oldest_valid <= 1'b0;
        exp_idx = '0;
        value_errors = 0;
        other_errors = 0;
        checks = 0;
        cur_test = "reset";
        load_table();
        waited = 0;
        tick_or_timeout(waited, "reset release");
        while (reset)
        begin
            tick_or_timeout(waited, "reset release");
        end
        for (r = 0; r < NUM_ROWS; r++)
        begin
            start_row(r);
            fork
                send_lines(row_lines[r]);
                supervise_row(r);
            join
            finish_row(r);
        end
        print_summary();
        if ((value_errors + other_errors) == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
